// File: src/aluPkg.sv
package aluPkg;

    // Datapath word width
    // Also the default for every module parameter of the same name
    parameter int DATA_WIDTH = 32;

    // Opcode encoding of the teaching datapath
    typedef enum logic [4:0] {
        OR   = 5'd0,
        AND  = 5'd1,
        NEG  = 5'd2,
        NOT  = 5'd3,
        // Rotates and shifts
        ROL  = 5'd4,
        ROR  = 5'd5,
        SHL  = 5'd6,
        SHRA = 5'd7,
        SHR  = 5'd8,
        // Add and subtract
        ADD  = 5'd9,
        SUB  = 5'd10,
        ADDU = 5'd11,
        // Multi-cycle ops
        MUL  = 5'd12,
        DIV  = 5'd13
    } aluOp;

    // One operation request, 69 bits at the default width
    typedef struct packed {
        aluOp                  op;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
    } aluRequest;

    // HI/LO register pair
    typedef struct packed {
        logic [DATA_WIDTH-1:0] high;
        logic [DATA_WIDTH-1:0] low;
    } aluHalves;

    // Z word, seen as one product or as a HI/LO pair
    // DIV puts the remainder in high and the quotient in low
    typedef union packed {
        logic [2*DATA_WIDTH-1:0] full;
        aluHalves                halves;
    } aluResult;

endpackage

// File: src/aluAdder.sv
`timescale 1ns/1ps

module aluAdder #(
    parameter int DATA_WIDTH = aluPkg::DATA_WIDTH
) (
    input  logic [DATA_WIDTH-1:0]   a,
    input  logic [DATA_WIDTH-1:0]   b,
    input  aluPkg::aluOp            op,
    output logic [2*DATA_WIDTH-1:0] sum
);
    import aluPkg::*;

    logic                isNeg;
    logic                isSub;
    logic                isUnsigned;
    // Operands widened by one bit for the exact result
    logic [DATA_WIDTH:0] left;
    logic [DATA_WIDTH:0] right;
    logic [DATA_WIDTH:0] total;

    assign isNeg      = (op == NEG);
    assign isSub      = (op == SUB);
    assign isUnsigned = (op == ADDU);

    // Operand steering into the single adder
    always_comb begin
        if (isNeg) begin
            // 0 - a, so a goes to the inverted side
            left  = '0;
            right = ~{a[DATA_WIDTH-1], a};
        end else begin
            // Zero extension only for ADDU
            left  = {a[DATA_WIDTH-1] & ~isUnsigned, a};
            right = isSub ? ~{b[DATA_WIDTH-1], b} : {b[DATA_WIDTH-1] & ~isUnsigned, b};
        end
    end

    // Carry in completes the two's complement
    assign total = left + right + {{DATA_WIDTH{1'b0}}, isSub | isNeg};

    // Top bit is the sign for signed ops
    // and the carry out for ADDU, which lands alone in the high word
    assign sum = {{(DATA_WIDTH-1){total[DATA_WIDTH] & ~isUnsigned}}, total};

endmodule

// File: src/aluShifter.sv
`timescale 1ns/1ps

module aluShifter #(
    parameter int DATA_WIDTH = aluPkg::DATA_WIDTH
) (
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [4:0]            amount,
    input  aluPkg::aluOp          op,
    output logic [DATA_WIDTH-1:0] shifted
);
    import aluPkg::*;

    localparam int STAGES = 5;

    logic rotate;
    logic shiftLeft;
    logic arith;
    // Stage 0 is the input, stage 5 the result
    logic [DATA_WIDTH-1:0] stage [0:STAGES];

    // Direction and fill kind
    assign rotate    = (op == ROL) || (op == ROR);
    assign shiftLeft = (op == ROL) || (op == SHL);
    assign arith     = (op == SHRA);

    assign stage[0] = a;

    // Barrel stages of 1, 2, 4, 8 and 16 bit positions
    for (genvar i = 0; i < STAGES; i++) begin : gStage
        localparam int STEP = 1 << i;

        logic [STEP-1:0] leftFill;
        logic [STEP-1:0] rightFill;

        // Bits shifted in from the right on a left move
        assign leftFill = rotate ? stage[i][DATA_WIDTH-1 -: STEP] : '0;

        // Bits shifted in from the left on a right move
        // Sign copies for SHRA, wrapped bits for ROR
        always_comb begin
            if (rotate) begin
                rightFill = stage[i][STEP-1:0];
            end else if (arith) begin
                rightFill = {STEP{stage[i][DATA_WIDTH-1]}};
            end else begin
                rightFill = '0;
            end
        end

        assign stage[i+1] = !amount[i] ? stage[i] :
                            shiftLeft  ? {stage[i][DATA_WIDTH-STEP-1:0], leftFill} :
                                         {rightFill, stage[i][DATA_WIDTH-1:STEP]};
    end

    assign shifted = stage[STAGES];

endmodule

// File: src/boothMultiplier.sv
`timescale 1ns/1ps

module boothMultiplier #(
    parameter int DATA_WIDTH = aluPkg::DATA_WIDTH
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    go,
    input  logic [DATA_WIDTH-1:0]   multiplicand,
    input  logic [DATA_WIDTH-1:0]   multiplier,
    output logic [2*DATA_WIDTH-1:0] product,
    output logic                    finish
);
    localparam int COUNT_WIDTH = $clog2(DATA_WIDTH) + 1;

    // Accumulator one bit wider so that subtracting the most negative value fits
    logic [DATA_WIDTH:0]    acc;
    logic [DATA_WIDTH-1:0]  low;
    logic                   lowMinus1;
    logic [DATA_WIDTH-1:0]  mcand;
    logic                   running;
    logic [COUNT_WIDTH-1:0] count;

    // Current step inputs
    logic [DATA_WIDTH:0]    curAcc;
    logic [DATA_WIDTH-1:0]  curLow;
    logic                   curMinus1;
    logic [DATA_WIDTH:0]    curMcand;
    logic [DATA_WIDTH:0]    addAcc;

    // Go seeds the first step straight from the ports
    always_comb begin
        curAcc    = go ? '0 : acc;
        curLow    = go ? multiplier : low;
        curMinus1 = go ? 1'b0 : lowMinus1;
        curMcand  = go ? {multiplicand[DATA_WIDTH-1], multiplicand} :
                         {mcand[DATA_WIDTH-1], mcand};
        // Booth recoding of the bit pair
        case ({curLow[0], curMinus1})
            2'b01:   addAcc = curAcc + curMcand;
            2'b10:   addAcc = curAcc - curMcand;
            default: addAcc = curAcc;
        endcase
    end

    // Step counter, first step happens on the go edge
    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
            count   <= '0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (go) begin
                running <= 1'b1;
                count   <= COUNT_WIDTH'(1);
            end else if (running) begin
                count <= count + 1'b1;
                // Last of DATA_WIDTH steps
                if (count == COUNT_WIDTH'(DATA_WIDTH - 1)) begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
            end
        end
    end

    // Arithmetic shift right of acc, low and the extra bit
    always_ff @(posedge clock) begin
        if (go || running) begin
            acc       <= {addAcc[DATA_WIDTH], addAcc[DATA_WIDTH:1]};
            low       <= {addAcc[0], curLow[DATA_WIDTH-1:1]};
            lowMinus1 <= curLow[0];
        end
        if (go) begin
            mcand <= multiplicand;
        end
    end

    assign product = {acc[DATA_WIDTH-1:0], low};

endmodule

// File: src/restoringDivider.sv
`timescale 1ns/1ps

module restoringDivider #(
    parameter int DATA_WIDTH = aluPkg::DATA_WIDTH
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  go,
    input  logic [DATA_WIDTH-1:0] dividend,
    input  logic [DATA_WIDTH-1:0] divisor,
    output logic [DATA_WIDTH-1:0] quotient,
    output logic [DATA_WIDTH-1:0] remainder,
    output logic                  finish
);
    localparam int COUNT_WIDTH = $clog2(DATA_WIDTH) + 1;

    logic [DATA_WIDTH-1:0]  rem;
    logic [DATA_WIDTH-1:0]  quo;
    logic [DATA_WIDTH-1:0]  dvs;
    logic                   negQuotient;
    logic                   negRemainder;
    logic                   stepping;
    logic                   fixing;
    logic [COUNT_WIDTH-1:0] count;

    // Magnitudes, the most negative value maps to its unsigned equal
    logic [DATA_WIDTH-1:0]  dividendMag;
    logic [DATA_WIDTH-1:0]  divisorMag;

    // Current step inputs
    logic [DATA_WIDTH-1:0]  curRem;
    logic [DATA_WIDTH-1:0]  curQuo;
    logic [DATA_WIDTH-1:0]  curDvs;
    logic [DATA_WIDTH:0]    shifted;
    logic [DATA_WIDTH+1:0]  trial;

    assign dividendMag = dividend[DATA_WIDTH-1] ? -dividend : dividend;
    assign divisorMag  = divisor[DATA_WIDTH-1] ? -divisor : divisor;

    // Shift in the next dividend bit and try the subtraction
    always_comb begin
        curRem  = go ? '0 : rem;
        curQuo  = go ? dividendMag : quo;
        curDvs  = go ? divisorMag : dvs;
        shifted = {curRem, curQuo[DATA_WIDTH-1]};
        trial   = {1'b0, shifted} - {2'b00, curDvs};
    end

    // Steps, then one sign fix cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            stepping <= 1'b0;
            fixing   <= 1'b0;
            count    <= '0;
            finish   <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (go) begin
                stepping <= 1'b1;
                fixing   <= 1'b0;
                count    <= COUNT_WIDTH'(1);
            end else if (stepping) begin
                count <= count + 1'b1;
                if (count == COUNT_WIDTH'(DATA_WIDTH - 1)) begin
                    stepping <= 1'b0;
                    fixing   <= 1'b1;
                end
            end else if (fixing) begin
                fixing <= 1'b0;
                finish <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (go || stepping) begin
            // Borrow means restore, quotient bit 0
            if (trial[DATA_WIDTH+1]) begin
                rem <= shifted[DATA_WIDTH-1:0];
                quo <= {curQuo[DATA_WIDTH-2:0], 1'b0};
            end else begin
                rem <= trial[DATA_WIDTH-1:0];
                quo <= {curQuo[DATA_WIDTH-2:0], 1'b1};
            end
        end else if (fixing) begin
            // Truncating division, remainder follows the dividend
            quo <= negQuotient ? -quo : quo;
            rem <= negRemainder ? -rem : rem;
        end
        if (go) begin
            dvs          <= divisorMag;
            negQuotient  <= dividend[DATA_WIDTH-1] ^ divisor[DATA_WIDTH-1];
            negRemainder <= dividend[DATA_WIDTH-1];
        end
    end

    assign quotient  = quo;
    assign remainder = rem;

endmodule

// File: src/aluTop.sv
`timescale 1ns/1ps

module aluTop #(
    parameter int DATA_WIDTH = aluPkg::DATA_WIDTH
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    input  aluPkg::aluRequest request,
    output aluPkg::aluResult  result,
    output logic              done,
    output logic              busy,
    output logic              divByZero
);
    import aluPkg::*;

    logic                    accept;
    logic                    isMul;
    logic                    isDiv;
    logic                    divisorZero;
    logic                    mulGo;
    logic                    divGo;
    logic                    mulFinish;
    logic                    divFinish;
    logic [2*DATA_WIDTH-1:0] addSum;
    logic [DATA_WIDTH-1:0]   shifted;
    logic [2*DATA_WIDTH-1:0] product;
    logic [DATA_WIDTH-1:0]   quotient;
    logic [DATA_WIDTH-1:0]   remainder;
    // Opcode of the op in flight, picks which finish to wait for
    aluOp                    pendingOp;
    aluResult                singleResult;

    // Start while busy is dropped
    assign accept      = start && !busy;
    assign isMul       = (request.op == MUL);
    assign isDiv       = (request.op == DIV);
    assign divisorZero = (request.b == '0);
    assign mulGo       = accept && isMul;
    // Zero divisor is answered here, the divider never sees it
    assign divGo       = accept && isDiv && !divisorZero;

    aluAdder #(.DATA_WIDTH(DATA_WIDTH)) u_aluAdder (
        .a   (request.a),
        .b   (request.b),
        .op  (request.op),
        .sum (addSum)
    );

    aluShifter #(.DATA_WIDTH(DATA_WIDTH)) u_aluShifter (
        .a       (request.a),
        .amount  (request.b[4:0]),
        .op      (request.op),
        .shifted (shifted)
    );

    boothMultiplier #(.DATA_WIDTH(DATA_WIDTH)) u_boothMultiplier (
        .clock        (clock),
        .reset        (reset),
        .go           (mulGo),
        .multiplicand (request.a),
        .multiplier   (request.b),
        .product      (product),
        .finish       (mulFinish)
    );

    restoringDivider #(.DATA_WIDTH(DATA_WIDTH)) u_restoringDivider (
        .clock     (clock),
        .reset     (reset),
        .go        (divGo),
        .dividend  (request.a),
        .divisor   (request.b),
        .quotient  (quotient),
        .remainder (remainder),
        .finish    (divFinish)
    );

    // Single-cycle results, unknown opcodes give zero
    always_comb begin
        singleResult = '0;
        case (request.op)
            OR:                       singleResult.halves.low = request.a | request.b;
            AND:                      singleResult.halves.low = request.a & request.b;
            NOT:                      singleResult.halves.low = ~request.a;
            NEG, ADD, SUB, ADDU:      singleResult.full = addSum;
            ROL, ROR, SHL, SHRA, SHR: singleResult.halves.low = shifted;
            default:                  singleResult = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result    <= '0;
            done      <= 1'b0;
            busy      <= 1'b0;
            divByZero <= 1'b0;
            pendingOp <= OR;
        end else begin
            done <= 1'b0;
            if (accept) begin
                pendingOp <= request.op;
                divByZero <= isDiv && divisorZero;
                if (isMul || (isDiv && !divisorZero)) begin
                    busy <= 1'b1;
                end else if (isDiv) begin
                    // Divide by zero: remainder a, quotient all ones
                    result.halves <= {request.a, {DATA_WIDTH{1'b1}}};
                    done          <= 1'b1;
                end else begin
                    result <= singleResult;
                    done   <= 1'b1;
                end
            end else if (busy) begin
                // busy drops on the same edge that raises done
                if (pendingOp == MUL && mulFinish) begin
                    result.full <= product;
                    busy        <= 1'b0;
                    done        <= 1'b1;
                end else if (pendingOp == DIV && divFinish) begin
                    result.halves <= {remainder, quotient};
                    busy          <= 1'b0;
                    done          <= 1'b1;
                end
            end
        end
    end

endmodule

// File: sim/alu_checker.sv
`timescale 1ns/1ps

module aluChecker (
    input logic              clock,
    input logic              reset,
    input logic              start,
    input aluPkg::aluRequest request,
    input logic              done,
    input logic              busy
);
    import aluPkg::*;

    // Failed assertions, read back by the testbench
    int failures = 0;

    logic singleOp;

    // Everything except MUL and DIV answers in one cycle
    assign singleOp = (request.op != MUL) && (request.op != DIV);

    // done is a one-cycle pulse
    doneIsPulse: assert property (@(posedge clock) disable iff (reset) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            failures++;
        end

    // busy drops on the edge that raises done
    busyFallsWithDone: assert property (@(posedge clock) disable iff (reset)
        $fell(busy) |-> done)
        else begin
            $error("busy fell without done");
            failures++;
        end

    // Either an accepted start or a running op before every done
    doneHasCause: assert property (@(posedge clock) disable iff (reset)
        done |-> ($past(start) || $past(busy)))
        else begin
            $error("done without a preceding start");
            failures++;
        end

    // Accepted single-cycle op
    singleOpLatency: assert property (@(posedge clock) disable iff (reset)
        (start && !busy && singleOp) |=> done)
        else begin
            $error("single-cycle op did not give done one cycle after start");
            failures++;
        end

endmodule

// File: sim/aluTb.sv
`timescale 1ns/1ps

module aluTb;
    import aluPkg::*;

    localparam int DATA_WIDTH = aluPkg::DATA_WIDTH;
    localparam int PERIOD     = 40;
    // Words per line of the pattern file
    localparam int FIELDS     = 6;
    localparam int MAX_TESTS  = 64;
    // Longest wait for done, also the watchdog budget per test
    localparam int MAX_WAIT   = DATA_WIDTH + 10;

    logic      clock;
    logic      reset;
    logic      start;
    aluRequest request;
    aluResult  result;
    logic      done;
    logic      busy;
    logic      divByZero;

    logic [31:0] patterns [0:MAX_TESTS*FIELDS-1];
    int          testCount;
    int          passCount;
    int          failCount;
    int          errorCount;
    int          checkerFailures;
    bit          loaded;
    integer      seed;

    aluTop #(.DATA_WIDTH(DATA_WIDTH)) u_aluTop (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .request   (request),
        .result    (result),
        .done      (done),
        .busy      (busy),
        .divByZero (divByZero)
    );

    // Protocol assertions on the DUT ports
    bind aluTop aluChecker u_aluChecker (
        .clock   (clock),
        .reset   (reset),
        .start   (start),
        .request (request),
        .done    (done),
        .busy    (busy)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD/2) clock = ~clock;
    end

    // Watchdog, armed once the pattern count is known
    initial begin
        wait (loaded);
        #((testCount * (MAX_WAIT + 2) + 4) * PERIOD);
        $display("Timeout: the pattern replay did not finish in the allowed time");
        $display("Test failed");
        $finish;
    end

    // Cycles from start to done, from the timing rules
    function automatic int expectedLatency(input aluOp op, input logic [31:0] b);
        if (op == MUL) begin
            return DATA_WIDTH + 1;
        end else if (op == DIV) begin
            // Zero divisor is answered at once
            return (b == '0) ? 1 : DATA_WIDTH + 2;
        end
        return 1;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic runTest(input int index);
        aluRequest   req;
        aluRequest   intruder;
        logic [31:0] expHigh;
        logic [31:0] expLow;
        logic        expDbz;
        int          cycles;
        int          errorsBefore;
        int          pick;
        bit          timedOut;
        req.op       = aluOp'(patterns[index*FIELDS][4:0]);
        req.a        = patterns[index*FIELDS+1];
        req.b        = patterns[index*FIELDS+2];
        expHigh      = patterns[index*FIELDS+3];
        expLow       = patterns[index*FIELDS+4];
        expDbz       = patterns[index*FIELDS+5][0];
        errorsBefore = errorCount;
        timedOut     = 1'b0;
        // Start pulse for one cycle
        @(posedge clock);
        #2;
        start   = 1'b1;
        request = req;
        @(posedge clock);
        #2;
        start  = 1'b0;
        cycles = 1;
        while (!done && !timedOut) begin
            if (req.op == MUL && cycles == 4) begin
                // Stray start in the middle of a MUL, must be dropped
                pick        = $unsigned($random(seed)) % 14;
                intruder.op = aluOp'(pick[4:0]);
                intruder.a  = $random(seed);
                intruder.b  = $random(seed);
                start       = 1'b1;
                request     = intruder;
            end else begin
                start   = 1'b0;
                request = req;
            end
            @(posedge clock);
            #2;
            cycles++;
            if (cycles > MAX_WAIT) begin
                timedOut = 1'b1;
            end
        end
        start   = 1'b0;
        request = req;
        if (timedOut) begin
            $display("Case %0d: no done pulse within %0d cycles of start", index, MAX_WAIT);
            errorCount++;
        end else begin
            checkValue("latency", cycles, expectedLatency(req.op, req.b));
            checkValue("result.halves.high", result.halves.high, expHigh);
            checkValue("result.halves.low", result.halves.low, expLow);
            checkValue("divByZero", divByZero, expDbz);
            checkValue("busy", busy, 1'b0);
            // Result held after done
            @(posedge clock);
            #2;
            checkValue("result held", result.full, {expHigh, expLow});
            checkValue("divByZero held", divByZero, expDbz);
        end
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("Case %0d op %0d a %h b %h: pass", index, req.op, req.a, req.b);
        end else begin
            failCount++;
            $display("Case %0d op %0d a %h b %h: mismatch", index, req.op, req.a, req.b);
        end
    endtask

    initial begin
        int index;
        // Inputs at known values from time zero
        reset      = 1'b1;
        start      = 1'b0;
        request    = '0;
        seed       = 32'h9de4;
        loaded     = 1'b0;
        testCount  = 0;
        passCount  = 0;
        failCount  = 0;
        errorCount = 0;
        // Unused entries stay all ones and mark the end
        for (index = 0; index < MAX_TESTS * FIELDS; index++) begin
            patterns[index] = '1;
        end
        $readmemh("sim/aluPatterns.mem", patterns);
        while (testCount < MAX_TESTS && patterns[testCount*FIELDS] !== 32'hFFFFFFFF) begin
            testCount++;
        end
        loaded = 1'b1;
        if (testCount == 0) begin
            $display("No test patterns could be read from the pattern file");
            errorCount++;
        end
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;
        for (index = 0; index < testCount; index++) begin
            runTest(index);
        end
        checkerFailures = u_aluTop.u_aluChecker.failures;
        $display("Summary: %0d cases, %0d passed, %0d failed, %0d check errors, %0d assertion failures",
                 testCount, passCount, failCount, errorCount, checkerFailures);
        if (failCount == 0 && errorCount == 0 && checkerFailures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sim/aluPatterns.mem
// Columns: op a b expHigh expLow expDivByZero, all hex
// One test per line, replayed in file order
00 12345678 0F0F0F0F 00000000 1F3F5F7F 0
01 12345678 0F0F0F0F 00000000 02040608 0
02 00000005 00000000 FFFFFFFF FFFFFFFB 0
02 FFFFFFF0 00000000 00000000 00000010 0
03 0F0F00FF 00000000 00000000 F0F0FF00 0
04 80000001 00000001 00000000 00000003 0
05 00000003 00000021 00000000 80000001 0
06 12345678 00000000 00000000 12345678 0
07 80000000 0000001F 00000000 FFFFFFFF 0
08 80000000 0000001F 00000000 00000001 0
04 12345678 0000001F 00000000 091A2B3C 0
09 FFFF0001 00000001 FFFFFFFF FFFF0002 0
0A 00050005 00050006 FFFFFFFF FFFFFFFF 0
09 7FFFFFFF 00000001 00000000 80000000 0
0B FFFF0000 00000001 00000000 FFFF0001 0
0B FFFFFFFF 00000001 00000001 00000000 0
0C FFFF0000 00000004 FFFFFFFF FFFC0000 0
0C 00000007 FFFFFFFD FFFFFFFF FFFFFFEB 0
0C 80000000 80000000 40000000 00000000 0
0D FFFFFFF9 00000002 FFFFFFFF FFFFFFFD 0
0D 00000007 FFFFFFFE 00000001 FFFFFFFD 0
0D FFFFFF9C FFFFFFF9 FFFFFFFE 0000000E 0
0D 80000000 00000000 80000000 FFFFFFFF 1
0E FFFFFFFF FFFFFFFF 00000000 00000000 0

// File: build.f
src/aluPkg.sv
src/aluAdder.sv
src/aluShifter.sv
src/boothMultiplier.sv
src/restoringDivider.sv
src/aluTop.sv
sim/alu_checker.sv
sim/aluTb.sv
